//--- video_base.f
video_types_pkg.sv
osd_cfg_pkg.sv
osd_overlay.sv
ypbpr_convert.sv
video_out_mux.sv
video_base.sv
video_base_assertions.sv
video_base_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the video pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps \
   -f video_base.f --top-module video_base_tb -o sim_video_base
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_video_base)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- video_base_tb.sv
// video pipeline testbench with bitmap load, stimulus table, reference model and checks
`default_nettype none
`timescale 1ns/10ps

module video_base_tb;

   import video_types_pkg::*;
   import osd_cfg_pkg::*;

   localparam int LINE_LEN = 32;
   localparam int N_LINES = 12;
   localparam int N_FLUSH = 2;
   localparam int N_ROWS = N_LINES * LINE_LEN + N_FLUSH;
   localparam int TIMEOUT_CYCLES = 2 * N_ROWS * 2 + 500;

   // one table row, stimulus first, then the expected pixel
   typedef struct packed {
      color4_t   gr;
      color4_t   gg;
      color4_t   gb;
      logic      hs;
      logic      vs;
      logic      lhbl;
      logic      lvbl;
      logic      osd_en;
      logic      ypbpr;
      logic      wr;
      osd_addr_t wa;
      osd_byte_t wd;
      color6_t   xr;
      color6_t   xg;
      color6_t   xb;
      color6_t   exp_r;
      color6_t   exp_g;
      color6_t   exp_b;
   } row_t;

   logic clk_sys;
   logic rst;
   logic pxl_cen;
   color4_t game_r;
   color4_t game_g;
   color4_t game_b;
   logic hs;
   logic vs;
   logic lhbl;
   logic lvbl;
   logic osd_en;
   logic ypbpr_mode;
   logic osd_wr;
   osd_addr_t osd_addr;
   osd_byte_t osd_data;
   color6_t vga_r;
   color6_t vga_g;
   color6_t vga_b;
   logic vga_hs;
   logic vga_vs;

   row_t tbl [N_ROWS];
   row_t pending [$];
   osd_byte_t bmp_ref [OSD_BYTES];
   integer seed;
   int color_errors;
   int sync_errors;
   int cycles;

   video_base u_video_base (.*);

   bind video_out_mux video_base_assertions u_video_base_assertions (.*);

   initial begin
      clk_sys = 1'b0;
      forever #5 clk_sys = ~clk_sys;
   end

   always @(posedge clk_sys) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, the stimulus loop did not finish", cycles);
         $display("Some tests failed");
         $finish;
      end
   end

   task automatic check_color6(string what, color6_t got, color6_t exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
         color_errors++;
      end
   endtask

   task automatic check_sync(string what, logic got, logic exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
         sync_errors++;
      end
   endtask

   // top two bits repeated below the 4-bit value
   function automatic color6_t widen(color4_t c);
      int v;
      v = int'(c);
      return color6_t'(v * 4 + v / 4);
   endfunction

   function automatic color6_t ref_chroma(color6_t c, int y);
      int d;
      int s;
      d = int'(c) - y;
      s = int'(PB_PR_MID) + (d >>> 1);
      if (s < 0)
         s = 0;
      if (s > 63)
         s = 63;
      return color6_t'(s);
   endfunction

   task automatic compare_outputs(row_t px, logic mode);
      color6_t er;
      color6_t eg;
      color6_t eb;
      logic ehs;
      logic evs;
      logic blank;
      int y;
      blank = !px.lhbl || !px.lvbl;
      if (mode) begin
         y = (int'(Y_KR) * int'(px.xr) + int'(Y_KG) * int'(px.xg)
              + int'(Y_KB) * int'(px.xb)) / 256;
         er = blank ? PB_PR_MID : ref_chroma(px.xr, y);
         eg = blank ? color6_t'(0) : color6_t'(y);
         eb = blank ? PB_PR_MID : ref_chroma(px.xb, y);
         ehs = !(px.hs ^ px.vs);
         evs = 1'b1;
      end else begin
         er = px.exp_r;
         eg = px.exp_g;
         eb = px.exp_b;
         ehs = px.hs;
         evs = px.vs;
      end
      check_color6("vga_r", vga_r, er);
      check_color6("vga_g", vga_g, eg);
      check_color6("vga_b", vga_b, eb);
      check_sync("vga_hs", vga_hs, ehs);
      check_sync("vga_vs", vga_vs, evs);
   endtask

   task automatic load_bitmap();
      osd_byte_t d;
      for (int a = 0; a < OSD_BYTES; a++) begin
         d = osd_byte_t'($random(seed));
         bmp_ref[a] = d;
         osd_wr = 1'b1;
         osd_addr = osd_addr_t'(a);
         osd_data = d;
         @(posedge clk_sys);
         #1;
      end
      osd_wr = 1'b0;
   endtask

   // stimulus rows, then the reference model walks them in order
   task automatic build_table();
      int line;
      int px;
      int h;
      int v;
      int col;
      logic hs_p;
      logic vs_p;
      logic hs_rise;
      logic in_win;
      logic lit;
      osd_byte_t cur;
      h = 0;
      v = 0;
      hs_p = 1'b0;
      vs_p = 1'b0;
      for (int i = 0; i < N_ROWS; i++) begin
         line = i / LINE_LEN;
         px = i % LINE_LEN;
         tbl[i] = '0;
         if (i < N_LINES * LINE_LEN) begin
            tbl[i].gr = color4_t'($random(seed));
            tbl[i].gg = color4_t'($random(seed));
            tbl[i].gb = color4_t'($random(seed));
            tbl[i].hs = (px < 3);
            tbl[i].vs = (line < 2);
            tbl[i].lhbl = (px >= 4);
            tbl[i].lvbl = (line >= 2);
            tbl[i].osd_en = (line != 10);
            tbl[i].ypbpr = (line == 3) || (line == 4) || (line == 11)
                           || (line == 5 && px >= 10 && px < 20);
            // rewrite row 1 of the window at the start of line 9
            if (line == 9 && px < 2) begin
               tbl[i].wr = 1'b1;
               tbl[i].wa = osd_addr_t'(8 + px);
               tbl[i].wd = (px == 0) ? 8'hA5 : 8'h3C;
            end
         end
         hs_rise = tbl[i].hs && !hs_p;
         h = hs_rise ? 0 : h + 1;
         if (tbl[i].vs && !vs_p)
            v = 0;
         else if (hs_rise)
            v = v + 1;
         hs_p = tbl[i].hs;
         vs_p = tbl[i].vs;
         in_win = tbl[i].osd_en && h >= OSD_X0 && h < OSD_X0 + OSD_W
                  && v >= OSD_Y0 && v < OSD_Y0 + OSD_H;
         lit = 1'b0;
         if (in_win) begin
            col = h - OSD_X0;
            cur = bmp_ref[(v - OSD_Y0) * (OSD_W / 8) + col / 8];
            lit = cur[7 - col % 8];
         end
         tbl[i].xr = widen(!in_win ? tbl[i].gr : (lit ? OSD_FG : tbl[i].gr >> 1));
         tbl[i].xg = widen(!in_win ? tbl[i].gg : (lit ? OSD_FG : tbl[i].gg >> 1));
         tbl[i].xb = widen(!in_win ? tbl[i].gb : (lit ? OSD_FG : tbl[i].gb >> 1));
         tbl[i].exp_r = (tbl[i].lhbl && tbl[i].lvbl) ? tbl[i].xr : color6_t'(0);
         tbl[i].exp_g = (tbl[i].lhbl && tbl[i].lvbl) ? tbl[i].xg : color6_t'(0);
         tbl[i].exp_b = (tbl[i].lhbl && tbl[i].lvbl) ? tbl[i].xb : color6_t'(0);
         // the write lands after this pixel has read the bitmap
         if (tbl[i].wr)
            bmp_ref[tbl[i].wa] = tbl[i].wd;
      end
   endtask

   // one strobe, then one idle cycle where the outputs must hold
   task automatic apply_row(int n);
      row_t px;
      game_r = tbl[n].gr;
      game_g = tbl[n].gg;
      game_b = tbl[n].gb;
      hs = tbl[n].hs;
      vs = tbl[n].vs;
      lhbl = tbl[n].lhbl;
      lvbl = tbl[n].lvbl;
      osd_en = tbl[n].osd_en;
      ypbpr_mode = tbl[n].ypbpr;
      osd_wr = tbl[n].wr;
      osd_addr = tbl[n].wa;
      osd_data = tbl[n].wd;
      pxl_cen = 1'b1;
      pending.push_back(tbl[n]);
      @(posedge clk_sys);
      #1;
      pxl_cen = 1'b0;
      osd_wr = 1'b0;
      px = pending.pop_front();
      compare_outputs(px, tbl[n].ypbpr);
      @(posedge clk_sys);
      #1;
      compare_outputs(px, tbl[n].ypbpr);
   endtask

   initial begin
      row_t reset_px;
      rst = 1'b1;
      pxl_cen = 1'b0;
      game_r = '0;
      game_g = '0;
      game_b = '0;
      hs = 1'b0;
      vs = 1'b0;
      lhbl = 1'b0;
      lvbl = 1'b0;
      osd_en = 1'b0;
      ypbpr_mode = 1'b0;
      osd_wr = 1'b0;
      osd_addr = '0;
      osd_data = '0;
      seed = 32'h6735;
      color_errors = 0;
      sync_errors = 0;
      cycles = 0;
      reset_px = '0;
      repeat (10) @(posedge clk_sys);
      #1;
      rst = 1'b0;
      compare_outputs(reset_px, 1'b0);
      load_bitmap();
      build_table();
      // two stages still hold reset values when the first pixel enters
      pending.push_back(reset_px);
      pending.push_back(reset_px);
      for (int n = 0; n < N_ROWS; n++)
         apply_row(n);
      $display("color errors: %0d, sync errors: %0d", color_errors, sync_errors);
      if (color_errors == 0 && sync_errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- video_base_assertions.sv
// concurrent assertions on the output stage, bound into video_out_mux
`default_nettype none
`timescale 1ns/10ps

module video_base_assertions (
   input wire                           clk_sys,
   input wire                           rst,
   input wire                           pxl_cen,
   input wire                           ypbpr_mode,
   input wire                           cv_lhbl,
   input wire                           cv_lvbl,
   input wire video_types_pkg::color6_t vga_r,
   input wire video_types_pkg::color6_t vga_g,
   input wire video_types_pkg::color6_t vga_b,
   input wire                           vga_hs,
   input wire                           vga_vs
);

   // vs is the constant high level in YPbPr mode
   a_ypbpr_vs_high: assert property (@(posedge clk_sys) disable iff (rst)
      (pxl_cen && ypbpr_mode) |=> vga_vs)
      else $error("vga_vs low after a strobe in YPbPr mode");

   // blanked RGB pixel gives black
   a_rgb_blank_black: assert property (@(posedge clk_sys) disable iff (rst)
      (pxl_cen && !ypbpr_mode && (!cv_lhbl || !cv_lvbl))
      |=> (vga_r == '0 && vga_g == '0 && vga_b == '0))
      else $error("RGB outputs not zero after a blanked strobe");

   a_outputs_known: assert property (@(posedge clk_sys) disable iff (rst)
      !$isunknown({vga_r, vga_g, vga_b, vga_hs, vga_vs}))
      else $error("video output unknown after reset");

endmodule

`default_nettype wire

//--- video_base.sv
// video output top level: OSD overlay, YPbPr conversion and output mux in a row
`default_nettype none
`timescale 1ns/10ps

module video_base (
   input  wire                      clk_sys,
   input  wire                      rst,
   input  wire                      pxl_cen,
   input  wire video_types_pkg::color4_t game_r,
   input  wire video_types_pkg::color4_t game_g,
   input  wire video_types_pkg::color4_t game_b,
   input  wire                      hs,
   input  wire                      vs,
   input  wire                      lhbl,
   input  wire                      lvbl,
   input  wire                      osd_en,
   input  wire                      ypbpr_mode,
   input  wire                      osd_wr,
   input  wire osd_cfg_pkg::osd_addr_t  osd_addr,
   input  wire osd_cfg_pkg::osd_byte_t  osd_data,
   output video_types_pkg::color6_t vga_r,
   output video_types_pkg::color6_t vga_g,
   output video_types_pkg::color6_t vga_b,
   output logic                     vga_hs,
   output logic                     vga_vs
);

   import video_types_pkg::*;

   // stage 1 to stage 2
   color4_t ov_r, ov_g, ov_b;
   logic    ov_hs, ov_vs, ov_lhbl, ov_lvbl;

   // stage 2 to stage 3
   color6_t rgb6_r, rgb6_g, rgb6_b;
   color6_t cy, cpb, cpr;
   logic    cv_hs, cv_vs, cv_lhbl, cv_lvbl;

   osd_overlay u_osd_overlay (
      .clk_sys (clk_sys), .rst (rst), .pxl_cen (pxl_cen),
      .osd_en  (osd_en),
      .osd_wr  (osd_wr), .osd_addr (osd_addr), .osd_data (osd_data),
      .game_r  (game_r), .game_g (game_g), .game_b (game_b),
      .hs      (hs), .vs (vs), .lhbl (lhbl), .lvbl (lvbl),
      .ov_r    (ov_r), .ov_g (ov_g), .ov_b (ov_b),
      .ov_hs   (ov_hs), .ov_vs (ov_vs), .ov_lhbl (ov_lhbl), .ov_lvbl (ov_lvbl)
   );

   ypbpr_convert u_ypbpr_convert (
      .clk_sys (clk_sys), .rst (rst), .pxl_cen (pxl_cen),
      .ov_r    (ov_r), .ov_g (ov_g), .ov_b (ov_b),
      .ov_hs   (ov_hs), .ov_vs (ov_vs), .ov_lhbl (ov_lhbl), .ov_lvbl (ov_lvbl),
      .rgb6_r  (rgb6_r), .rgb6_g (rgb6_g), .rgb6_b (rgb6_b),
      .cy      (cy), .cpb (cpb), .cpr (cpr),
      .cv_hs   (cv_hs), .cv_vs (cv_vs), .cv_lhbl (cv_lhbl), .cv_lvbl (cv_lvbl)
   );

   video_out_mux u_video_out_mux (
      .clk_sys    (clk_sys), .rst (rst), .pxl_cen (pxl_cen),
      .ypbpr_mode (ypbpr_mode),
      .rgb6_r     (rgb6_r), .rgb6_g (rgb6_g), .rgb6_b (rgb6_b),
      .cy         (cy), .cpb (cpb), .cpr (cpr),
      .cv_hs      (cv_hs), .cv_vs (cv_vs), .cv_lhbl (cv_lhbl), .cv_lvbl (cv_lvbl),
      .vga_r      (vga_r), .vga_g (vga_g), .vga_b (vga_b),
      .vga_hs     (vga_hs), .vga_vs (vga_vs)
   );

endmodule

`default_nettype wire

//--- video_out_mux.sv
// stage 3: blanking, RGB or YPbPr output selection and composite sync
`default_nettype none
`timescale 1ns/10ps

module video_out_mux (
   input  wire                      clk_sys,
   input  wire                      rst,
   input  wire                      pxl_cen,
   input  wire                      ypbpr_mode,
   input  wire video_types_pkg::color6_t rgb6_r,
   input  wire video_types_pkg::color6_t rgb6_g,
   input  wire video_types_pkg::color6_t rgb6_b,
   input  wire video_types_pkg::color6_t cy,
   input  wire video_types_pkg::color6_t cpb,
   input  wire video_types_pkg::color6_t cpr,
   input  wire                      cv_hs,
   input  wire                      cv_vs,
   input  wire                      cv_lhbl,
   input  wire                      cv_lvbl,
   output video_types_pkg::color6_t vga_r,
   output video_types_pkg::color6_t vga_g,
   output video_types_pkg::color6_t vga_b,
   output logic                     vga_hs,
   output logic                     vga_vs
);

   import video_types_pkg::*;

   logic    blank;
   color6_t nxt_r;
   color6_t nxt_g;
   color6_t nxt_b;
   logic    nxt_hs;
   logic    nxt_vs;

   always_comb begin
      blank = ~cv_lhbl | ~cv_lvbl;
      if (ypbpr_mode) begin
         // Pr, Y, Pb on the red, green and blue pins
         nxt_r  = blank ? PB_PR_MID : cpr;
         nxt_g  = blank ? color6_t'(0) : cy;
         nxt_b  = blank ? PB_PR_MID : cpb;
         // composite sync on HS while VS stays high
         nxt_hs = ~(cv_hs ^ cv_vs);
         nxt_vs = 1'b1;
      end else begin
         nxt_r  = blank ? color6_t'(0) : rgb6_r;
         nxt_g  = blank ? color6_t'(0) : rgb6_g;
         nxt_b  = blank ? color6_t'(0) : rgb6_b;
         // separate syncs pass through even while blanked
         nxt_hs = cv_hs;
         nxt_vs = cv_vs;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (rst) begin
         vga_r  <= '0;
         vga_g  <= '0;
         vga_b  <= '0;
         vga_hs <= 1'b0;
         vga_vs <= 1'b0;
      end else if (pxl_cen) begin
         vga_r  <= nxt_r;
         vga_g  <= nxt_g;
         vga_b  <= nxt_b;
         vga_hs <= nxt_hs;
         vga_vs <= nxt_vs;
      end
   end

endmodule

`default_nettype wire

//--- ypbpr_convert.sv
// stage 2: 4 to 6 bit colour expansion and integer RGB to YPbPr conversion
`default_nettype none
`timescale 1ns/10ps

module ypbpr_convert (
   input  wire                      clk_sys,
   input  wire                      rst,
   input  wire                      pxl_cen,
   input  wire video_types_pkg::color4_t ov_r,
   input  wire video_types_pkg::color4_t ov_g,
   input  wire video_types_pkg::color4_t ov_b,
   input  wire                      ov_hs,
   input  wire                      ov_vs,
   input  wire                      ov_lhbl,
   input  wire                      ov_lvbl,
   output video_types_pkg::color6_t rgb6_r,
   output video_types_pkg::color6_t rgb6_g,
   output video_types_pkg::color6_t rgb6_b,
   output video_types_pkg::color6_t cy,
   output video_types_pkg::color6_t cpb,
   output video_types_pkg::color6_t cpr,
   output logic                     cv_hs,
   output logic                     cv_vs,
   output logic                     cv_lhbl,
   output logic                     cv_lvbl
);

   import video_types_pkg::*;

   color6_t              e_r;
   color6_t              e_g;
   color6_t              e_b;
   logic [Y_SUM_W-1:0]   y_sum;
   color6_t              y_c;

   // repeat the top bits so 4'hF maps to full scale
   function automatic color6_t expand(color4_t c);
      return {c, c[3:2]};
   endfunction

   // midpoint plus half the colour difference clamped to 0..63
   function automatic color6_t chroma(color6_t c, color6_t y);
      logic signed [8:0] diff;
      logic signed [8:0] sum;
      color6_t           res;
      diff = $signed({3'b000, c}) - $signed({3'b000, y});
      sum  = $signed({3'b000, PB_PR_MID}) + (diff >>> 1);
      if (sum < 0)
         res = '0;
      else if (sum > 9'sd63)
         res = 6'd63;
      else
         res = sum[5:0];
      return res;
   endfunction

   always_comb begin
      e_r   = expand(ov_r);
      e_g   = expand(ov_g);
      e_b   = expand(ov_b);
      y_sum = Y_SUM_W'(Y_KR * e_r + Y_KG * e_g + Y_KB * e_b);
      // weights add up to 256
      y_c   = y_sum[Y_SUM_W-1:8];
   end

   always_ff @(posedge clk_sys) begin
      if (rst) begin
         rgb6_r  <= '0;
         rgb6_g  <= '0;
         rgb6_b  <= '0;
         cy      <= '0;
         cpb     <= '0;
         cpr     <= '0;
         cv_hs   <= 1'b0;
         cv_vs   <= 1'b0;
         cv_lhbl <= 1'b0;
         cv_lvbl <= 1'b0;
      end else if (pxl_cen) begin
         rgb6_r  <= e_r;
         rgb6_g  <= e_g;
         rgb6_b  <= e_b;
         cy      <= y_c;
         cpb     <= chroma(e_b, y_c);
         cpr     <= chroma(e_r, y_c);
         cv_hs   <= ov_hs;
         cv_vs   <= ov_vs;
         cv_lhbl <= ov_lhbl;
         cv_lvbl <= ov_lvbl;
      end
   end

endmodule

`default_nettype wire

//--- osd_overlay.sv
// stage 1: raster counters, OSD bitmap memory and overlay on the game colour
`default_nettype none
`timescale 1ns/10ps

module osd_overlay (
   input  wire                      clk_sys,
   input  wire                      rst,
   input  wire                      pxl_cen,
   input  wire                      osd_en,
   input  wire                      osd_wr,
   input  wire osd_cfg_pkg::osd_addr_t  osd_addr,
   input  wire osd_cfg_pkg::osd_byte_t  osd_data,
   input  wire video_types_pkg::color4_t game_r,
   input  wire video_types_pkg::color4_t game_g,
   input  wire video_types_pkg::color4_t game_b,
   input  wire                      hs,
   input  wire                      vs,
   input  wire                      lhbl,
   input  wire                      lvbl,
   output video_types_pkg::color4_t ov_r,
   output video_types_pkg::color4_t ov_g,
   output video_types_pkg::color4_t ov_b,
   output logic                     ov_hs,
   output logic                     ov_vs,
   output logic                     ov_lhbl,
   output logic                     ov_lvbl
);

   import video_types_pkg::*;
   import osd_cfg_pkg::*;

   osd_byte_t bitmap [OSD_BYTES];

   hpos_t     h_cnt;
   hpos_t     h_cur;
   hpos_t     h_rel;
   vpos_t     v_cnt;
   vpos_t     v_cur;
   vpos_t     v_rel;
   logic      hs_q;
   logic      vs_q;
   logic      hs_rise;
   logic      vs_rise;
   logic      in_win;
   osd_addr_t rd_addr;
   osd_byte_t rd_byte;
   logic      osd_bit;

   // lit pixel takes the foreground, dark pixel dims the game colour
   function automatic color4_t overlay_ch(color4_t c, logic win, logic lit);
      color4_t res;
      if (!win)
         res = c;
      else if (lit)
         res = OSD_FG;
      else
         res = c >> 1;
      return res;
   endfunction

   // host writes do not wait for the pixel enable
   always_ff @(posedge clk_sys) begin
      if (osd_wr)
         bitmap[osd_addr] <= osd_data;
   end

   always_comb begin
      hs_rise = hs & ~hs_q;
      vs_rise = vs & ~vs_q;
      // position of the pixel sampled on this strobe
      h_cur = hs_rise ? hpos_t'(0) : hpos_t'(h_cnt + 1'b1);
      if (vs_rise)
         v_cur = '0;
      else if (hs_rise)
         v_cur = vpos_t'(v_cnt + 1'b1);
      else
         v_cur = v_cnt;
      // wrap-around subtraction turns the window test into one compare
      h_rel = h_cur - hpos_t'(OSD_X0);
      v_rel = v_cur - vpos_t'(OSD_Y0);
      in_win = osd_en && (h_rel < hpos_t'(OSD_W)) && (v_rel < vpos_t'(OSD_H));
      // row * 8 + column / 8
      rd_addr = osd_addr_t'({v_rel[OSD_ROW_W-1:0], h_rel[OSD_COL_W-1:3]});
      rd_byte = bitmap[rd_addr];
      // bit 7 is the leftmost pixel of a byte
      osd_bit = rd_byte[3'd7 - h_rel[2:0]];
   end

   always_ff @(posedge clk_sys) begin
      if (rst) begin
         h_cnt   <= '0;
         v_cnt   <= '0;
         hs_q    <= 1'b0;
         vs_q    <= 1'b0;
         ov_r    <= '0;
         ov_g    <= '0;
         ov_b    <= '0;
         ov_hs   <= 1'b0;
         ov_vs   <= 1'b0;
         ov_lhbl <= 1'b0;
         ov_lvbl <= 1'b0;
      end else if (pxl_cen) begin
         h_cnt   <= h_cur;
         v_cnt   <= v_cur;
         hs_q    <= hs;
         vs_q    <= vs;
         ov_r    <= overlay_ch(game_r, in_win, osd_bit);
         ov_g    <= overlay_ch(game_g, in_win, osd_bit);
         ov_b    <= overlay_ch(game_b, in_win, osd_bit);
         ov_hs   <= hs;
         ov_vs   <= vs;
         ov_lhbl <= lhbl;
         ov_lvbl <= lvbl;
      end
   end

endmodule

`default_nettype wire

//--- osd_cfg_pkg.sv
// OSD window geometry, bitmap size, foreground level and write port types
`default_nettype none

package osd_cfg_pkg;

   // window origin in raster coordinates
   localparam int unsigned OSD_X0 = 16;
   localparam int unsigned OSD_Y0 = 8;

   // window size in pixels
   localparam int unsigned OSD_W = 64;
   localparam int unsigned OSD_H = 16;

   // 1 bit per pixel, 8 pixels per byte
   localparam int unsigned OSD_BYTES = OSD_W * OSD_H / 8;

   // column and row index widths inside the window
   localparam int unsigned OSD_COL_W = $clog2(OSD_W);
   localparam int unsigned OSD_ROW_W = $clog2(OSD_H);

   // host write port
   typedef logic [$clog2(OSD_BYTES)-1:0] osd_addr_t;
   typedef logic [7:0]                   osd_byte_t;

   // channel level of a lit OSD pixel
   localparam logic [3:0] OSD_FG = 4'hF;

endpackage

`default_nettype wire

//--- video_types_pkg.sv
// colour and raster position types, luma weights and chroma midpoint
`default_nettype none

package video_types_pkg;

   // one game colour channel as delivered by the core
   typedef logic [3:0] color4_t;

   // one output channel, RGB or Y/Pb/Pr
   typedef logic [5:0] color6_t;

   // raster position
   typedef logic [8:0] hpos_t;
   typedef logic [8:0] vpos_t;

   // zero level of Pb and Pr, also used for blanked chroma
   localparam color6_t PB_PR_MID = 6'd32;

   // luma weights add up to 256 so Y is a shift by 8
   localparam int unsigned Y_KR = 77;
   localparam int unsigned Y_KG = 150;
   localparam int unsigned Y_KB = 29;

   // weighted sum of three 6-bit channels fits in 14 bits
   localparam int unsigned Y_SUM_W = 14;

endpackage

`default_nettype wire
